// File: src/soc_bus_pkg.sv
package soc_bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int PAGE_W = 3;          // 8 led pages

    // one address word seen either flat or as region + offset
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [3:0]  region;
            logic [27:0] offset;
        } fld;
    } bus_addr_t;

    localparam logic [3:0] REGION_MEM = 4'd0;
    localparam logic [3:0] REGION_LED = 4'd2;

    localparam logic [1:0] RESP_OK     = 2'd0;
    localparam logic [1:0] RESP_DECERR = 2'd3;

    localparam logic [DATA_W-1:0] ERR_RDATA = 32'hDEAD_BEEF;

    // byte-lane merge of write data into an old word
    function automatic logic [DATA_W-1:0] byte_merge(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] wdata,
        input logic [STRB_W-1:0] strb
    );
        logic [DATA_W-1:0] word;
        word = old_word;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                word[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return word;
    endfunction

endpackage

// File: src/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter import soc_bus_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              a_req,
    input  logic              a_we,
    input  bus_addr_t         a_addr,
    input  logic [DATA_W-1:0] a_wdata,
    input  logic [STRB_W-1:0] a_strb,
    input  logic              b_req,
    input  logic              b_we,
    input  bus_addr_t         b_addr,
    input  logic [DATA_W-1:0] b_wdata,
    input  logic [STRB_W-1:0] b_strb,
    output logic              bus_req,
    output logic              bus_owner,    // 0 = a, 1 = b
    output logic              bus_we,
    output bus_addr_t         bus_addr,
    output logic [DATA_W-1:0] bus_wdata,
    output logic [STRB_W-1:0] bus_strb
);

    logic              turn;            // high when b wins the next conflict
    logic              hold_vld;
    logic              hold_owner;
    logic              hold_we;
    bus_addr_t         hold_addr;
    logic [DATA_W-1:0] hold_wdata;
    logic [STRB_W-1:0] hold_strb;

    logic both;
    logic pick_b;
    logic park;
    logic park_b;

    assign both   = a_req && b_req;
    assign pick_b = both ? turn : b_req;

    // hold slot goes out first so any new strobe waits one cycle
    assign park   = hold_vld ? (a_req || b_req) : both;
    assign park_b = hold_vld ? pick_b : !pick_b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_req  <= 1'b0;
            hold_vld <= 1'b0;
            turn     <= 1'b0;
        end else begin
            bus_req  <= hold_vld || a_req || b_req;
            hold_vld <= park;
            if (both && !hold_vld) begin
                turn <= ~turn;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hold_vld) begin
            bus_owner <= hold_owner;
            bus_we    <= hold_we;
            bus_addr  <= hold_addr;
            bus_wdata <= hold_wdata;
            bus_strb  <= hold_strb;
        end else if (pick_b) begin
            bus_owner <= 1'b1;
            bus_we    <= b_we;
            bus_addr  <= b_addr;
            bus_wdata <= b_wdata;
            bus_strb  <= b_strb;
        end else begin
            bus_owner <= 1'b0;
            bus_we    <= a_we;
            bus_addr  <= a_addr;
            bus_wdata <= a_wdata;
            bus_strb  <= a_strb;
        end

        if (park) begin
            hold_owner <= park_b;
            hold_we    <= park_b ? b_we : a_we;
            hold_addr  <= park_b ? b_addr : a_addr;
            hold_wdata <= park_b ? b_wdata : a_wdata;
            hold_strb  <= park_b ? b_strb : a_strb;
        end
    end

endmodule

// File: src/bus_fabric.sv
`timescale 1ns/1ns

module bus_fabric import soc_bus_pkg::*; #(
    parameter int MEM_DEPTH_LOG2 = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      bus_req,
    input  logic                      bus_owner,
    input  logic                      bus_we,
    input  bus_addr_t                 bus_addr,
    input  logic [DATA_W-1:0]         bus_wdata,
    input  logic [STRB_W-1:0]         bus_strb,
    input  logic [DATA_W-1:0]         mem_rdata,
    input  logic [DATA_W-1:0]         led_rdata,
    output logic                      mem_sel,
    output logic                      led_sel,
    output logic                      sl_we,
    output logic [MEM_DEPTH_LOG2-1:0] sl_index,
    output logic [DATA_W-1:0]         sl_wdata,
    output logic [STRB_W-1:0]         sl_strb,
    output logic                      a_rsp,
    output logic                      b_rsp,
    output logic [DATA_W-1:0]         rdata,
    output logic [1:0]                resp,
    output logic                      err_evt
);

    logic hit_mem;
    logic hit_led;

    // response stage lines up with the slave read registers
    logic rsp_vld;
    logic rsp_owner;
    logic rsp_mem;
    logic rsp_err;

    assign hit_mem = bus_addr.fld.region == REGION_MEM;
    assign hit_led = bus_addr.fld.region == REGION_LED;

    assign mem_sel  = bus_req && hit_mem;
    assign led_sel  = bus_req && hit_led;
    assign sl_we    = bus_we;
    assign sl_index = bus_addr.raw[MEM_DEPTH_LOG2+1:2];   // word index wraps in region 0
    assign sl_wdata = bus_wdata;
    assign sl_strb  = bus_strb;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_vld   <= 1'b0;
            rsp_owner <= 1'b0;
            rsp_mem   <= 1'b0;
            rsp_err   <= 1'b0;
        end else begin
            rsp_vld   <= bus_req;
            rsp_owner <= bus_owner;
            rsp_mem   <= hit_mem;
            rsp_err   <= !(hit_mem || hit_led);
        end
    end

    assign a_rsp   = rsp_vld && !rsp_owner;
    assign b_rsp   = rsp_vld && rsp_owner;
    assign err_evt = rsp_vld && rsp_err;

    always_comb begin
        if (rsp_err) begin
            rdata = ERR_RDATA;
            resp  = RESP_DECERR;
        end else begin
            rdata = rsp_mem ? mem_rdata : led_rdata;
            resp  = RESP_OK;
        end
    end

endmodule

// File: src/mem_slave.sv
`timescale 1ns/1ns

module mem_slave import soc_bus_pkg::*; #(
    parameter int MEM_DEPTH_LOG2 = 8
) (
    input  logic                      clk,
    input  logic                      mem_sel,
    input  logic                      sl_we,
    input  logic [MEM_DEPTH_LOG2-1:0] sl_index,
    input  logic [DATA_W-1:0]         sl_wdata,
    input  logic [STRB_W-1:0]         sl_strb,
    output logic [DATA_W-1:0]         mem_rdata
);

    localparam int DEPTH = 1 << MEM_DEPTH_LOG2;

    logic [DATA_W-1:0] mem [0:DEPTH-1];
    logic [DATA_W-1:0] cur_word;
    logic [DATA_W-1:0] new_word;

    assign cur_word = mem[sl_index];
    assign new_word = byte_merge(cur_word, sl_wdata, sl_strb);

    always_ff @(posedge clk) begin
        if (mem_sel && sl_we) begin
            mem[sl_index] <= new_word;
        end
    end

    // a write returns the merged word
    always_ff @(posedge clk) begin
        if (mem_sel) begin
            mem_rdata <= sl_we ? new_word : cur_word;
        end
    end

endmodule

// File: src/led_slave.sv
`timescale 1ns/1ns

module led_slave import soc_bus_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              led_sel,
    input  logic              sl_we,
    input  logic [DATA_W-1:0] sl_wdata,
    input  logic [STRB_W-1:0] sl_strb,
    output logic [DATA_W-1:0] led_rdata,
    output logic [DATA_W-1:0] led_reg
);

    logic [DATA_W-1:0] led_next;

    // no offset decode so the whole region aliases this register
    assign led_next = byte_merge(led_reg, sl_wdata, sl_strb);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led_reg <= '0;
        end else if (led_sel && sl_we) begin
            led_reg <= led_next;
        end
    end

    always_ff @(posedge clk) begin
        if (led_sel) begin
            led_rdata <= sl_we ? led_next : led_reg;
        end
    end

endmodule

// File: src/led_status_pager.sv
`timescale 1ns/1ns

module led_status_pager import soc_bus_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              btn_up,
    input  logic              btn_down,
    input  logic              a_rsp,
    input  logic              b_rsp,
    input  logic              err_evt,
    input  logic [DATA_W-1:0] led_reg,
    output logic [7:0]        led8,     // active low
    output logic [3:0]        led4
);

    logic [PAGE_W-1:0] page;
    logic [7:0]        cnt_a;
    logic [7:0]        cnt_b;
    logic [7:0]        cnt_err;
    logic [7:0]        page_byte;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            page    <= '0;
            cnt_a   <= '0;
            cnt_b   <= '0;
            cnt_err <= '0;
        end else begin
            if (btn_up && !btn_down) begin
                page <= page + 1'b1;        // wraps 7 -> 0
            end else if (btn_down && !btn_up) begin
                page <= page - 1'b1;
            end
            if (a_rsp)   cnt_a   <= cnt_a + 1'b1;
            if (b_rsp)   cnt_b   <= cnt_b + 1'b1;
            if (err_evt) cnt_err <= cnt_err + 1'b1;
        end
    end

    always_comb begin
        case (page)
            3'd4:    page_byte = cnt_a;
            3'd5:    page_byte = cnt_b;
            3'd6:    page_byte = cnt_err;
            3'd7:    page_byte = 8'h55;
            default: page_byte = led_reg[8*page[1:0] +: 8];  // register bytes from low to high
        endcase
    end

    assign led8 = ~page_byte;
    assign led4 = {{(4-PAGE_W){1'b0}}, page};

endmodule

// File: src/soc_bus_top.sv
`timescale 1ns/1ns

module soc_bus_top import soc_bus_pkg::*; #(
    parameter int MEM_DEPTH_LOG2 = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              a_req,
    input  logic              a_we,
    input  logic [ADDR_W-1:0] a_addr,
    input  logic [DATA_W-1:0] a_wdata,
    input  logic [STRB_W-1:0] a_strb,
    output logic              a_rsp,
    output logic [DATA_W-1:0] a_rdata,
    output logic [1:0]        a_resp,
    input  logic              b_req,
    input  logic              b_we,
    input  logic [ADDR_W-1:0] b_addr,
    input  logic [DATA_W-1:0] b_wdata,
    input  logic [STRB_W-1:0] b_strb,
    output logic              b_rsp,
    output logic [DATA_W-1:0] b_rdata,
    output logic [1:0]        b_resp,
    input  logic              btn_up,
    input  logic              btn_down,
    output logic [7:0]        led8,
    output logic [3:0]        led4
);

    logic                      bus_req;
    logic                      bus_owner;
    logic                      bus_we;
    bus_addr_t                 bus_addr;
    logic [DATA_W-1:0]         bus_wdata;
    logic [STRB_W-1:0]         bus_strb;
    logic                      mem_sel;
    logic                      led_sel;
    logic                      sl_we;
    logic [MEM_DEPTH_LOG2-1:0] sl_index;
    logic [DATA_W-1:0]         sl_wdata;
    logic [STRB_W-1:0]         sl_strb;
    logic [DATA_W-1:0]         mem_rdata;
    logic [DATA_W-1:0]         led_rdata;
    logic [DATA_W-1:0]         led_reg;
    logic [DATA_W-1:0]         rdata;
    logic [1:0]                resp;
    logic                      err_evt;

    // shared return bus qualified per requester by its rsp strobe
    assign a_rdata = rdata;
    assign a_resp  = resp;
    assign b_rdata = rdata;
    assign b_resp  = resp;

    bus_arbiter i_arbiter (
        .clk       (clk      ),
        .rst_n     (rst_n    ),
        .a_req     (a_req    ),
        .a_we      (a_we     ),
        .a_addr    (a_addr   ),
        .a_wdata   (a_wdata  ),
        .a_strb    (a_strb   ),
        .b_req     (b_req    ),
        .b_we      (b_we     ),
        .b_addr    (b_addr   ),
        .b_wdata   (b_wdata  ),
        .b_strb    (b_strb   ),
        .bus_req   (bus_req  ),
        .bus_owner (bus_owner),
        .bus_we    (bus_we   ),
        .bus_addr  (bus_addr ),
        .bus_wdata (bus_wdata),
        .bus_strb  (bus_strb )
    );

    bus_fabric #(
        .MEM_DEPTH_LOG2 (MEM_DEPTH_LOG2)
    ) i_fabric (
        .clk       (clk      ),
        .rst_n     (rst_n    ),
        .bus_req   (bus_req  ),
        .bus_owner (bus_owner),
        .bus_we    (bus_we   ),
        .bus_addr  (bus_addr ),
        .bus_wdata (bus_wdata),
        .bus_strb  (bus_strb ),
        .mem_rdata (mem_rdata),
        .led_rdata (led_rdata),
        .mem_sel   (mem_sel  ),
        .led_sel   (led_sel  ),
        .sl_we     (sl_we    ),
        .sl_index  (sl_index ),
        .sl_wdata  (sl_wdata ),
        .sl_strb   (sl_strb  ),
        .a_rsp     (a_rsp    ),
        .b_rsp     (b_rsp    ),
        .rdata     (rdata    ),
        .resp      (resp     ),
        .err_evt   (err_evt  )
    );

    mem_slave #(
        .MEM_DEPTH_LOG2 (MEM_DEPTH_LOG2)
    ) i_mem (
        .clk       (clk      ),
        .mem_sel   (mem_sel  ),
        .sl_we     (sl_we    ),
        .sl_index  (sl_index ),
        .sl_wdata  (sl_wdata ),
        .sl_strb   (sl_strb  ),
        .mem_rdata (mem_rdata)
    );

    led_slave i_led (
        .clk       (clk      ),
        .rst_n     (rst_n    ),
        .led_sel   (led_sel  ),
        .sl_we     (sl_we    ),
        .sl_wdata  (sl_wdata ),
        .sl_strb   (sl_strb  ),
        .led_rdata (led_rdata),
        .led_reg   (led_reg  )
    );

    led_status_pager i_pager (
        .clk      (clk     ),
        .rst_n    (rst_n   ),
        .btn_up   (btn_up  ),
        .btn_down (btn_down),
        .a_rsp    (a_rsp   ),
        .b_rsp    (b_rsp   ),
        .err_evt  (err_evt ),
        .led_reg  (led_reg ),
        .led8     (led8    ),
        .led4     (led4    )
    );

endmodule

// File: verification/soc_bus_tb.sv
`timescale 1ns/1ns

module soc_bus_tb import soc_bus_pkg::*; ();

    localparam int MEM_LOG2 = 8;

    logic clk, rst_n, a_req, a_we, b_req, b_we, btn_up, btn_down, a_rsp, b_rsp;
    logic [ADDR_W-1:0] a_addr, b_addr;
    logic [DATA_W-1:0] a_wdata, b_wdata, a_rdata, b_rdata;
    logic [STRB_W-1:0] a_strb, b_strb;
    logic [1:0]        a_resp, b_resp;
    logic [7:0]        led8;
    logic [3:0]        led4;

    logic [31:0] model_mem [0:(1<<MEM_LOG2)-1];
    logic [31:0] model_led;
    logic [2:0]  model_page;
    logic [7:0]  model_cnt_a, model_cnt_b, model_cnt_err;
    logic        model_turn;                // high when b wins the next conflict
    logic [66:0] q_a[$];                    // {chk, due, rdata, resp}
    logic [66:0] q_b[$];
    string       vec_q[$];
    int          ncyc, errors, cur_test, n_vec, n_pass, n_fail;
    integer      seed;

    always #4 clk = ~clk;

    soc_bus_top #(.MEM_DEPTH_LOG2(MEM_LOG2)) i_dut (
        .clk(clk), .rst_n(rst_n),
        .a_req(a_req), .a_we(a_we), .a_addr(a_addr), .a_wdata(a_wdata), .a_strb(a_strb),
        .a_rsp(a_rsp), .a_rdata(a_rdata), .a_resp(a_resp),
        .b_req(b_req), .b_we(b_we), .b_addr(b_addr), .b_wdata(b_wdata), .b_strb(b_strb),
        .b_rsp(b_rsp), .b_rdata(b_rdata), .b_resp(b_resp),
        .btn_up(btn_up), .btn_down(btn_down), .led8(led8), .led4(led4)
    );

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: test %0d %s is %h, expected %h",
                     $time, cur_test, what, got, exp);
            errors++;
        end
    endtask

    function automatic logic [7:0] page_led8();
        logic [31:0] sh;
        logic [7:0]  pb;
        sh = model_led >> {model_page[1:0], 3'b000};
        case (model_page)
            3'd4:    pb = model_cnt_a;
            3'd5:    pb = model_cnt_b;
            3'd6:    pb = model_cnt_err;
            3'd7:    pb = 8'h55;
            default: pb = sh[7:0];
        endcase
        return ~pb;                         // leds are active low
    endfunction

    task automatic predict_access(input logic we, input logic [31:0] addr,
                                  input logic [31:0] wdata, input logic [3:0] strb,
                                  output logic [31:0] d, output logic [1:0] r);
        logic [31:0]         mask;
        logic [MEM_LOG2-1:0] idx;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        idx = addr[MEM_LOG2+1:2];           // wraps modulo depth
        r = RESP_OK;
        d = ERR_RDATA;
        if (addr[31:28] == REGION_MEM) begin
            if (we) model_mem[idx] = (model_mem[idx] & ~mask) | (wdata & mask);
            d = model_mem[idx];
        end else if (addr[31:28] == REGION_LED) begin
            if (we) model_led = (model_led & ~mask) | (wdata & mask);
            d = model_led;
        end else begin
            r = RESP_DECERR;
        end
    endtask

    task automatic send_request(input bit side, input logic we, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [3:0] strb, input int lat,
                                output logic [31:0] pd, output logic [1:0] pr);
        logic [31:0] due;
        logic        chk;
        predict_access(we, addr, wdata, strb, pd, pr);
        chk = !we || pr != RESP_OK;         // write data comes back as don't-care
        due = ncyc + lat;
        if (side) begin
            {b_req, b_we, b_addr, b_wdata, b_strb} = {1'b1, we, addr, wdata, strb};
            q_b.push_back({chk, due, pd, pr});
            model_cnt_b = model_cnt_b + 8'd1;
        end else begin
            {a_req, a_we, a_addr, a_wdata, a_strb} = {1'b1, we, addr, wdata, strb};
            q_a.push_back({chk, due, pd, pr});
            model_cnt_a = model_cnt_a + 8'd1;
        end
        if (pr != RESP_OK) model_cnt_err = model_cnt_err + 8'd1;
    endtask

    task automatic take_response(input bit side, input logic rsp_now,
                                 input logic [31:0] rd, input logic [1:0] rs);
        logic [66:0] e;
        int          pending;
        pending = side ? q_b.size() : q_a.size();
        if (rsp_now && pending == 0) begin
            $display("test %0d: response on %s with nothing outstanding at cycle %0d",
                     cur_test, side ? "b" : "a", ncyc);
            errors++;
        end else if (pending > 0) begin
            e = side ? q_b[0] : q_a[0];
            if (rsp_now || e[65:34] <= ncyc) begin
                if (side) e = q_b.pop_front();
                else e = q_a.pop_front();
                if (!rsp_now) begin
                    $display("test %0d: response on %s missing at cycle %0d",
                             cur_test, side ? "b" : "a", ncyc);
                    errors++;
                end else begin
                    compare("rsp cycle", ncyc, e[65:34]);
                    if (e[66]) compare("rdata", rd, e[33:2]);
                    compare("resp", {30'd0, rs}, {30'd0, e[1:0]});
                end
            end
        end
    endtask

    // one falling edge with strobes dropped after the responses are taken
    task automatic next_cycle();
        @(negedge clk);
        ncyc++;
        take_response(1'b0, a_rsp, a_rdata, a_resp);
        take_response(1'b1, b_rsp, b_rdata, b_resp);
        a_req = 1'b0;
        b_req = 1'b0;
        btn_up = 1'b0;
        btn_down = 1'b0;
    endtask

    task automatic check_leds(input logic [31:0] e8, input logic [31:0] e4);
        compare("led8", {24'd0, led8}, e8);
        compare("led4", {28'd0, led4}, e4);
        compare("model led8", {24'd0, page_led8()}, e8);
        compare("model led4", {29'd0, model_page}, e4);
    endtask

    task automatic run_vector(input string line);
        string       op, dir;
        int          tnum, cnt, nf, k, first_err;
        logic [31:0] we_a, ad_a, wd_a, st_a, ed_a, er_a, we_b, ad_b, wd_b, st_b, ed_b, er_b;
        logic [31:0] pd_a, pd_b, rnd_word;
        logic [1:0]  pr_a, pr_b;
        nf = $sscanf(line, "%d %s", tnum, op);
        cur_test = tnum;
        first_err = errors;
        if (op == "a" || op == "b") begin
            nf = $sscanf(line, "%d %s %h %h %h %h %h %h", tnum, op, we_a, ad_a, wd_a, st_a,
                         ed_a, er_a);
            next_cycle();
            send_request(op == "b", we_a[0], ad_a, wd_a, st_a[3:0], 2, pd_a, pr_a);
            compare("model rdata", pd_a, ed_a);
            compare("model resp", {30'd0, pr_a}, er_a);
        end else if (op == "ab") begin
            nf = $sscanf(line, "%d %s %h %h %h %h %h %h %h %h %h %h %h %h", tnum, op, we_a,
                         ad_a, wd_a, st_a, ed_a, er_a, we_b, ad_b, wd_b, st_b, ed_b, er_b);
            next_cycle();
            if (model_turn) begin           // loser waits one extra cycle in the hold slot
                send_request(1'b1, we_b[0], ad_b, wd_b, st_b[3:0], 2, pd_b, pr_b);
                send_request(1'b0, we_a[0], ad_a, wd_a, st_a[3:0], 3, pd_a, pr_a);
            end else begin
                send_request(1'b0, we_a[0], ad_a, wd_a, st_a[3:0], 2, pd_a, pr_a);
                send_request(1'b1, we_b[0], ad_b, wd_b, st_b[3:0], 3, pd_b, pr_b);
            end
            model_turn = !model_turn;
            compare("model rdata a", pd_a, ed_a);
            compare("model resp a", {30'd0, pr_a}, er_a);
            compare("model rdata b", pd_b, ed_b);
            compare("model resp b", {30'd0, pr_b}, er_b);
        end else if (op == "btn") begin
            nf = $sscanf(line, "%d %s %s %d %h %h", tnum, op, dir, cnt, ed_a, er_a);
            for (k = 0; k < cnt; k++) begin
                next_cycle();
                if (dir == "up") begin
                    btn_up = 1'b1;
                    model_page = model_page + 3'd1;
                end else begin
                    btn_down = 1'b1;
                    model_page = model_page - 3'd1;
                end
                next_cycle();
            end
            check_leds(ed_a, er_a);
        end else if (op == "rst") begin
            nf = $sscanf(line, "%d %s %h %h", tnum, op, ed_a, er_a);
            compare("a_rsp", {31'd0, a_rsp}, 32'd0);
            compare("b_rsp", {31'd0, b_rsp}, 32'd0);
            check_leds(ed_a, er_a);
        end else if (op == "rnd" || op == "alt") begin
            nf = $sscanf(line, "%d %s %h %d", tnum, op, ad_a, cnt);
            for (k = 0; k < cnt; k++) begin
                next_cycle();
                if (op == "alt") begin      // a and b take turns every cycle
                    send_request(k[0], 1'b0, ad_a + 4 * k, 32'd0, 4'h0, 2, pd_a, pr_a);
                end else begin
                    rnd_word = $random(seed);
                    send_request(1'b0, 1'b1, ad_a + 4 * k, rnd_word, 4'hf, 2, pd_a, pr_a);
                    next_cycle();
                end
            end
            for (k = 0; op == "rnd" && k < cnt; k++) begin
                next_cycle();
                send_request(1'b1, 1'b0, ad_a + 4 * k, 32'd0, 4'h0, 2, pd_b, pr_b);
                next_cycle();
            end
        end else begin
            $display("test %0d: unknown operation %s in the test data", tnum, op);
            errors++;
        end
        while (q_a.size() > 0 || q_b.size() > 0) next_cycle();
        if (errors == first_err) begin
            n_pass++;
            $display("test %0d %s: ok", tnum, op);
        end else begin
            n_fail++;
            $display("test %0d %s: %0d errors", tnum, op, errors - first_err);
        end
    endtask

    initial begin
        wait (n_vec > 0);
        repeat (n_vec * 10 + 200) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", n_vec * 10 + 200);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int    fd;
        string line;
        {clk, rst_n, a_req, a_we, b_req, b_we, btn_up, btn_down} = '0;
        {a_addr, a_wdata, a_strb, b_addr, b_wdata, b_strb} = '0;
        {model_led, model_page, model_cnt_a, model_cnt_b, model_cnt_err, model_turn} = '0;
        {ncyc, errors, cur_test, n_vec, n_pass, n_fail} = '0;
        seed = 94;
        fd = $fopen("verification/soc_bus_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/soc_bus_testdata.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") vec_q.push_back(line);
            end
            $fclose(fd);
        end
        n_vec = vec_q.size();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        foreach (vec_q[i]) run_vector(vec_q[i]);
        $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errors);
        if (errors == 0 && n_fail == 0 && n_vec > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: soc_bus_top.f
src/soc_bus_pkg.sv
src/bus_arbiter.sv
src/bus_fabric.sv
src/mem_slave.sv
src/led_slave.sv
src/led_status_pager.sv
src/soc_bus_top.sv
verification/soc_bus_tb.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= soc_bus_tb
RTL_TOP   ?= soc_bus_top
FILELIST  ?= soc_bus_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
RTL_SRCS  ?= $(shell grep '^src/' $(FILELIST))

.PHONY: all build sim lint clean

all: sim

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/soc_bus_testdata.txt
# test op fields; a/b: we addr wdata strb rdata resp; ab: a fields, then b fields
# btn: up|dn presses led8 led4; rst: led8 led4; rnd/alt: addr count (model only)
1 rst ff 0
2 btn dn 1 aa 7
3 btn up 1 ff 0
4 a 1 00000010 12345678 f 12345678 0
5 b 0 00000010 00000000 0 12345678 0
6 a 1 00000010 aabbccdd 5 12bb56dd 0
7 a 0 00000010 00000000 0 12bb56dd 0
8 a 1 00000404 cafef00d f cafef00d 0
9 b 0 00000004 00000000 0 cafef00d 0
10 a 1 20000000 a1b2c3d4 f a1b2c3d4 0
11 b 1 20000008 00ee0000 4 a1eec3d4 0
12 b 0 2000fffc 00000000 0 a1eec3d4 0
13 btn up 1 3c 1
14 btn up 2 5e 3
15 a 0 10000000 00000000 0 deadbeef 3
16 b 1 f0000040 11111111 f deadbeef 3
17 a 0 30000000 00000000 0 deadbeef 3
18 btn up 3 fc 6
19 ab 1 00000020 01010101 f 01010101 0 1 00000024 02020202 f 02020202 0
20 ab 0 00000020 00000000 0 01010101 0 0 00000024 00000000 0 02020202 0
21 ab 0 00000024 00000000 0 02020202 0 0 90000000 00000000 0 deadbeef 3
22 rnd 00000100 6
23 alt 00000100 6
24 btn dn 2 ec 4
25 btn up 1 ee 5
26 btn up 2 aa 7
27 btn up 1 2b 0
